// ==== rtl/burstDataRam.sv ====
`timescale 1ns/1ns
`include "writeBuffer_defs.svh"

module burstDataRam
    import writeBufferPkg::*;
(
    input  logic                  clk,
    // Write port from the intake
    input  logic                  ramWe,
    input  logic [SlotAddrW-1:0]  ramWaddr,
    input  logic [`WB_DATA_W-1:0] ramWdata,
    // Read port towards the PHY
    input  logic                  ramRe,
    input  logic [SlotAddrW-1:0]  ramRaddr,
    output logic [`WB_DATA_W-1:0] ramRdata
);

    // --------------------
    // Storage
    // --------------------
    logic [`WB_DATA_W-1:0] mem [SlotCount];    // One slot per beat of every entry

    always_ff @(posedge clk) begin
        if (ramWe) begin
            mem[ramWaddr] <= ramWdata;
        end
    end

    // Read data holds between reads
    always_ff @(posedge clk) begin
        if (ramRe) begin
            ramRdata <= mem[ramRaddr];
        end
    end

endmodule

// ==== rtl/burstIntake.sv ====
`timescale 1ns/1ns
`include "writeBuffer_defs.svh"

module burstIntake
    import writeBufferPkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    // Frontend write channel
    input  logic [`WB_DATA_W-1:0] writeData,
    input  logic [`WB_ID_W-1:0]   writeDataId,
    input  logic [`WB_USER_W-1:0] writeDataUser,
    input  logic [`WB_BURST-1:0]  writeDataStrb,    // One bit per beat
    input  logic                  writeDataLast,
    input  logic                  writeDataValid,
    input  logic                  writeAckReady,
    output logic                  writeAckValid,
    output logic [`WB_ID_W-1:0]   writeAckId,
    output logic [`WB_USER_W-1:0] writeAckUser,
    // Directory status
    input  logic [`WB_IDX_W-1:0]  freeIdx,
    input  logic                  bufferFull,
    // Allocation towards the directory
    output logic                  lastAccept,
    output logic [`WB_IDX_W-1:0]  allocIdx,
    output logic [`WB_ID_W-1:0]   allocId,
    output logic [`WB_USER_W-1:0] allocUser,
    output logic [`WB_BURST-1:0]  allocStrb,
    // Data RAM write port
    output logic                  ramWe,
    output logic [SlotAddrW-1:0]  ramWaddr,
    output logic [`WB_DATA_W-1:0] ramWdata
);

    logic                  inBurst;     // First beat taken, last still due
    logic [`WB_IDX_W-1:0]  heldIdx;     // Entry fixed at the first beat
    logic [`WB_BEAT_W-1:0] beatCnt;     // Beat position inside the burst
    logic                  beatAccept;

    // --------------------
    // Beat acceptance
    // --------------------
    // A new burst needs a free entry; the last beat also needs the response slot
    assign beatAccept = writeDataValid && (inBurst || !bufferFull)
                        && (!writeDataLast || writeAckReady);
    assign lastAccept = beatAccept && writeDataLast;

    // Mid-burst the latched entry is used, so a free elsewhere cannot move us
    assign allocIdx  = inBurst ? heldIdx : freeIdx;
    assign allocId   = writeDataId;         // Metadata is taken on the last beat
    assign allocUser = writeDataUser;
    assign allocStrb = writeDataStrb;

    // Storage write
    assign ramWe    = beatAccept;
    assign ramWaddr = dataSlot(allocIdx, beatCnt);
    assign ramWdata = writeData;

    // Response rides on the accepted last beat
    assign writeAckValid = lastAccept;
    assign writeAckId    = writeDataId;
    assign writeAckUser  = writeDataUser;

    // --------------------
    // Burst tracking
    // --------------------
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            inBurst <= 1'b0;
            heldIdx <= '0;
            beatCnt <= '0;
        end else if (beatAccept) begin
            if (writeDataLast) begin
                inBurst <= 1'b0;            // Back to idle for the next burst
                beatCnt <= '0;
            end else begin
                inBurst <= 1'b1;
                beatCnt <= beatCnt + 1'b1;
                if (!inBurst) begin
                    heldIdx <= freeIdx;     // Lock the entry on the first beat
                end
            end
        end
    end

endmodule

// ==== rtl/burstStreamer.sv ====
`timescale 1ns/1ns
`include "writeBuffer_defs.svh"

module burstStreamer
    import writeBufferPkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    // Directory view
    input  logic [`WB_DEPTH-1:0]  issuedVec,
    input  logic [`WB_BURST-1:0]  entryStrb,
    output logic [`WB_IDX_W-1:0]  strbIdx,
    output logic                  serveDone,
    output logic [`WB_IDX_W-1:0]  serveIdx,
    // PHY FIFO level
    input  logic                  phyFifoReady,
    // Data RAM read port
    output logic                  ramRe,
    output logic [SlotAddrW-1:0]  ramRaddr,
    // PHY side, aligned with the RAM read data
    output logic                  phyStrb,
    output logic                  phyLast,
    output logic                  phyValid
);

    logic                  locked;      // Burst in flight
    logic [`WB_IDX_W-1:0]  lockIdx;     // Entry owning the burst
    logic [`WB_BEAT_W-1:0] beatCnt;     // Next beat to send
    logic                  serving;
    logic                  lastBeat;

    // --------------------
    // Entry selection
    // --------------------
    // A lower entry issued mid-burst waits until this one is done
    assign serveIdx = locked ? lockIdx : lowestSet(issuedVec);
    assign serving  = phyFifoReady && (locked || |issuedVec);
    assign lastBeat = (beatCnt == `WB_BEAT_W'(`WB_BURST - 1));

    assign serveDone = serving && lastBeat;     // Frees the entry at the next edge
    assign strbIdx   = serveIdx;
    assign ramRe     = serving;
    assign ramRaddr  = dataSlot(serveIdx, beatCnt);

    // --------------------
    // Beat sequencing
    // --------------------
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            locked   <= 1'b0;
            lockIdx  <= '0;
            beatCnt  <= '0;
            phyValid <= 1'b0;
            phyLast  <= 1'b0;
        end else begin
            phyValid <= serving;                // Low on a stall, position kept
            phyLast  <= serving && lastBeat;
            if (serving) begin
                lockIdx <= serveIdx;
                locked  <= !lastBeat;
                beatCnt <= lastBeat ? '0 : beatCnt + 1'b1;
            end
        end
    end

    // Strobe bit of the beat being read
    always_ff @(posedge clk) begin
        if (serving) begin
            phyStrb <= entryStrb[beatCnt];
        end
    end

endmodule

// ==== rtl/entryDirectory.sv ====
`timescale 1ns/1ns
`include "writeBuffer_defs.svh"

module entryDirectory
    import writeBufferPkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    // Allocation from the intake
    input  logic                  lastAccept,
    input  logic [`WB_IDX_W-1:0]  allocIdx,
    input  logic [`WB_ID_W-1:0]   allocId,
    input  logic [`WB_USER_W-1:0] allocUser,
    input  logic [`WB_BURST-1:0]  allocStrb,
    // Command issue from the channel scheduler
    input  logic                  issueValid,
    input  logic [`WB_ID_W-1:0]   issueId,
    input  logic [`WB_USER_W-1:0] issueUser,
    // Streamer side
    input  logic                  serveDone,
    input  logic [`WB_IDX_W-1:0]  serveIdx,
    input  logic [`WB_IDX_W-1:0]  strbIdx,
    // PHY completion
    input  logic                  writeModeAck,
    // Status
    output logic [`WB_IDX_W-1:0]  freeIdx,
    output logic                  bufferFull,
    output logic [`WB_DEPTH-1:0]  issuedVec,
    output logic [`WB_BURST-1:0]  entryStrb,
    output logic [`WB_CNT_W-1:0]  outstanding
);

    // --------------------
    // Entry state
    // --------------------
    logic [`WB_DEPTH-1:0]  validVec;                // Entry holds a complete burst
    logic [`WB_ID_W-1:0]   entryId   [`WB_DEPTH];
    logic [`WB_USER_W-1:0] entryUser [`WB_DEPTH];
    logic [`WB_BURST-1:0]  entryMask [`WB_DEPTH];   // Per-beat strobe
    logic [`WB_DEPTH-1:0]  matchVec;                // Issue candidates
    logic [`WB_IDX_W-1:0]  issueIdx;

    // Free and full status
    assign freeIdx    = lowestSet(~validVec);
    assign bufferFull = &validVec;

    // Strobe lookup for the streamer
    assign entryStrb = entryMask[strbIdx];

    // --------------------
    // Issue matching
    // --------------------
    // Only valid entries still waiting for their command take part
    always_comb begin
        for (int i = 0; i < `WB_DEPTH; i++) begin
            matchVec[i] = validVec[i] && !issuedVec[i]
                          && (entryId[i] == issueId)
                          && (entryUser[i] == issueUser);
        end
    end

    assign issueIdx = lowestSet(matchVec);      // Oldest slot is not tracked, lowest index wins

    // --------------------
    // Valid and issued flags
    // --------------------
    // Alloc, issue and free never hit the same entry in one cycle
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            validVec  <= '0;
            issuedVec <= '0;
        end else begin
            if (lastAccept) begin
                validVec[allocIdx]  <= 1'b1;
                issuedVec[allocIdx] <= 1'b0;
            end
            if (issueValid && |matchVec) begin     // Unmatched pulses are dropped
                issuedVec[issueIdx] <= 1'b1;
            end
            if (serveDone) begin                    // Last beat went out
                validVec[serveIdx]  <= 1'b0;
                issuedVec[serveIdx] <= 1'b0;
            end
        end
    end

    // Metadata captured with the last beat
    always_ff @(posedge clk) begin
        if (lastAccept) begin
            entryId[allocIdx]   <= allocId;
            entryUser[allocIdx] <= allocUser;
            entryMask[allocIdx] <= allocStrb;
        end
    end

    // --------------------
    // Outstanding writes
    // --------------------
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            outstanding <= '0;
        end else begin
            case ({lastAccept, writeModeAck})
                2'b10:   outstanding <= outstanding + 1'b1;  // Burst accepted
                2'b01:   outstanding <= outstanding - 1'b1;  // PHY finished one
                default: outstanding <= outstanding;         // Both or neither
            endcase
        end
    end

endmodule

// ==== rtl/writeBufferCtrl.sv ====
`timescale 1ns/1ns
`include "writeBuffer_defs.svh"

module writeBufferCtrl (
    input  logic                  clk,
    input  logic                  rst,
    // Frontend write channel
    input  logic [`WB_DATA_W-1:0] writeData,
    input  logic [`WB_ID_W-1:0]   writeDataId,
    input  logic [`WB_USER_W-1:0] writeDataUser,
    input  logic [`WB_BURST-1:0]  writeDataStrb,
    input  logic                  writeDataLast,
    input  logic                  writeDataValid,
    input  logic                  writeAckReady,
    output logic                  writeAckValid,
    output logic [`WB_ID_W-1:0]   writeAckId,
    output logic [`WB_USER_W-1:0] writeAckUser,
    output logic                  bufferFull,
    output logic [`WB_CNT_W-1:0]  outstanding,
    // Channel scheduler issue
    input  logic                  issueValid,
    input  logic [`WB_ID_W-1:0]   issueId,
    input  logic [`WB_USER_W-1:0] issueUser,
    // PHY channel
    input  logic                  phyFifoReady,
    input  logic                  writeModeAck,
    output logic [`WB_DATA_W-1:0] phyData,
    output logic                  phyStrb,
    output logic                  phyLast,
    output logic                  phyValid
);

    // --------------------
    // Internal wiring
    // --------------------
    logic                           lastAccept;
    logic [`WB_IDX_W-1:0]           allocIdx, freeIdx, serveIdx, strbIdx;
    logic [`WB_ID_W-1:0]            allocId;
    logic [`WB_USER_W-1:0]          allocUser;
    logic [`WB_BURST-1:0]           allocStrb, entryStrb;
    logic [`WB_DEPTH-1:0]           issuedVec;
    logic                           serveDone, ramWe, ramRe;
    logic [`WB_IDX_W+`WB_BEAT_W-1:0] ramWaddr, ramRaddr;   // Entry and beat
    logic [`WB_DATA_W-1:0]          ramWdata;

    burstIntake intake (.clk, .rst, .writeData, .writeDataId, .writeDataUser, .writeDataStrb,
        .writeDataLast, .writeDataValid, .writeAckReady, .writeAckValid, .writeAckId,
        .writeAckUser, .freeIdx, .bufferFull, .lastAccept, .allocIdx, .allocId, .allocUser,
        .allocStrb, .ramWe, .ramWaddr, .ramWdata);

    entryDirectory directory (.clk, .rst, .lastAccept, .allocIdx, .allocId, .allocUser,
        .allocStrb, .issueValid, .issueId, .issueUser, .serveDone, .serveIdx, .strbIdx,
        .writeModeAck, .freeIdx, .bufferFull, .issuedVec, .entryStrb, .outstanding);

    burstStreamer streamer (.clk, .rst, .issuedVec, .entryStrb, .strbIdx, .serveDone,
        .serveIdx, .phyFifoReady, .ramRe, .ramRaddr, .phyStrb, .phyLast, .phyValid);

    // RAM read data goes straight to the PHY, in step with phyValid
    burstDataRam dataRam (.clk, .ramWe, .ramWaddr, .ramWdata, .ramRe, .ramRaddr,
        .ramRdata(phyData));

endmodule

// ==== rtl/writeBufferPkg.sv ====
`include "writeBuffer_defs.svh"

package writeBufferPkg;

    // --------------------
    // Data storage layout
    // --------------------
    localparam int SlotCount = `WB_DEPTH * `WB_BURST;   // Words in burstDataRam
    localparam int SlotAddrW = `WB_IDX_W + `WB_BEAT_W;  // Entry index above beat number

    // Lowest set bit of an entry vector
    // Returns zero for an empty vector, callers qualify with a reduction OR
    function automatic logic [`WB_IDX_W-1:0] lowestSet(input logic [`WB_DEPTH-1:0] vec);
        logic [`WB_IDX_W-1:0] idx;
        idx = '0;
        for (int i = `WB_DEPTH - 1; i >= 0; i--) begin  // Scan downward so the lowest wins
            if (vec[i]) begin
                idx = i[`WB_IDX_W-1:0];
            end
        end
        return idx;
    endfunction

    // Storage address of one beat of one entry
    function automatic logic [SlotAddrW-1:0] dataSlot(
        input logic [`WB_IDX_W-1:0]  entry,
        input logic [`WB_BEAT_W-1:0] beat
    );
        logic [31:0] flat;
        flat = entry * `WB_BURST + beat;    // Bursts sit back to back
        return flat[SlotAddrW-1:0];
    endfunction

endpackage

// ==== rtl/writeBuffer_defs.svh ====
`ifndef WRITEBUFFER_DEFS_SVH
`define WRITEBUFFER_DEFS_SVH

// --------------------
// Buffer geometry
// --------------------
`define WB_DEPTH   8        // Directory entries, one burst each
`define WB_BURST   8        // Beats per burst

// --------------------
// Field widths
// --------------------
`define WB_DATA_W  64       // Data beat width
`define WB_ID_W    4        // Write ID
`define WB_USER_W  1        // Write user field

// Index and counter widths, kept in step with the sizes above
`define WB_IDX_W   3        // Entry index for WB_DEPTH entries
`define WB_BEAT_W  3        // Beat number for WB_BURST beats
`define WB_CNT_W   4        // Outstanding count, must hold WB_DEPTH

`endif

// ==== run.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it and scan the log for a failure
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal --top-module tbWriteBuffer -f writeBufferCtrl.f \
    -Mdir obj_dir -o simWriteBuffer > build.log 2>&1 \
    && ./obj_dir/simWriteBuffer > sim.log 2>&1 \
    || { cat build.log; echo "Build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "Regression failed" sim.log && exit 1 || exit 0

// ==== testbench/tbWriteBuffer.sv ====
`timescale 1ns/1ns
`include "writeBuffer_defs.svh"

module tbWriteBuffer;

    // --------------------
    // DUT and checker signals
    // --------------------
    logic                  clk, rst;
    logic [`WB_DATA_W-1:0] writeData, phyData;
    logic [`WB_ID_W-1:0]   writeDataId, writeAckId, issueId;
    logic [`WB_USER_W-1:0] writeDataUser, writeAckUser, issueUser;
    logic [`WB_BURST-1:0]  writeDataStrb;
    logic                  writeDataLast, writeDataValid, writeAckReady, writeAckValid;
    logic                  bufferFull, issueValid, phyFifoReady, writeModeAck;
    logic                  phyStrb, phyLast, phyValid, chkValid;
    logic [`WB_CNT_W-1:0]  outstanding, chkCount;
    int                    errorCount, checkCount;

    int                    ackLow, issueWait;   // Cycles left of ack-ready low and deferred issue
    logic                  randomReady, pairAck;
    logic [`WB_ID_W-1:0]   heldId;
    logic [`WB_USER_W-1:0] heldUser;

    localparam string TraceFile = "testbench/writeBuffer_trace.txt";

    writeBufferCtrl uut (.*);
    wbChecker scoreboard (.*);

    always #50 clk = ~clk;      // 100 ns period

    // Worst case cycle count of the trace with stalled bursts
    function automatic int traceBudget();
        int          tf, total;
        string       text;
        logic [63:0] a, b, c, d, e;
        total = 300;
        tf = $fopen(TraceFile, "r");
        while (tf != 0 && $fgets(text, tf) > 0) begin
            a = 0;
            e = 0;
            void'($sscanf(text.substr(1, text.len() - 1), "%h %h %h %h %h", a, b, c, d, e));
            if (text.getc(0) == "B") total += 4 * `WB_BURST * int'(e);
            else if (text.getc(0) == "W") total += int'(a);
            else total += 2;
        end
        if (tf != 0) $fclose(tf);
        return total;
    endfunction

    // Pulses drop and per-cycle levels refresh at the next falling edge
    task automatic nextCycle();
        @(negedge clk);
        issueValid    = 1'b0;
        writeModeAck  = 1'b0;
        chkValid      = 1'b0;
        writeAckReady = (ackLow == 0);
        if (ackLow > 0) ackLow--;
        if (randomReady) phyFifoReady = ($urandom % 4) != 0;   // Ready about 3 cycles in 4
        if (issueWait > 0) begin
            issueWait--;
            if (issueWait == 0) begin
                issueValid = 1'b1;
                issueId    = heldId;
                issueUser  = heldUser;
            end
        end
    endtask

    // Data word carries the ID on top and the beat number at the bottom
    task automatic sendBurst(input logic [`WB_ID_W-1:0] id, input logic [`WB_USER_W-1:0] user,
                             input logic [`WB_BURST-1:0] strb, input logic [51:0] base);
        logic taken;
        for (int b = 0; b < `WB_BURST; b++) begin
            nextCycle();
            writeDataValid = 1'b1;
            writeData      = {id, base, 8'(b)};
            writeDataId    = id;
            writeDataUser  = user;
            writeDataStrb  = strb;
            writeDataLast  = (b == `WB_BURST - 1);
            if (writeDataLast) begin
                writeModeAck = pairAck;
                pairAck      = 1'b0;
            end
            taken = (b > 0 || !bufferFull) && (!writeDataLast || writeAckReady);
            while (!taken) begin            // Beat held until the DUT can take it
                nextCycle();
                taken = (b > 0 || !bufferFull) && (!writeDataLast || writeAckReady);
            end
        end
        nextCycle();
        writeDataValid = 1'b0;
        writeDataLast  = 1'b0;
    endtask

    initial begin : watchdog
        int limit;
        limit = traceBudget();
        #(limit * 100);
        $display("Timeout after %0d cycles, the trace did not complete", limit);
        $display("Regression failed");
        $finish;
    end

    initial begin : main
        int          fd;
        string       line;
        byte         kind;
        logic [63:0] f1, f2, f3, f4, f5;
        void'($urandom(64));        // Seed the random stream once
        {clk, rst, writeData, writeDataId, writeDataUser, writeDataStrb} = '0;
        {writeDataLast, writeDataValid, issueValid, issueId, issueUser} = '0;
        {phyFifoReady, writeModeAck, chkValid, chkCount, randomReady, pairAck} = '0;
        {heldId, heldUser} = '0;
        writeAckReady = 1'b1;
        ackLow        = 0;
        issueWait     = 0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b1;
        fd = $fopen(TraceFile, "r");
        if (fd == 0) begin
            $display("Could not open the trace file %s", TraceFile);
            $display("Regression failed");
            $finish;
        end else begin
            while ($fgets(line, fd) > 0) begin
                {f1, f2, f3, f4, f5} = '0;
                kind = line.getc(0);
                void'($sscanf(line.substr(1, line.len() - 1), "%h %h %h %h %h",
                              f1, f2, f3, f4, f5));
                case (kind)
                    "R": begin
                        nextCycle();
                        randomReady  = (f1 == 2);
                        phyFifoReady = (f1 != 0);
                    end
                    "A": ackLow = int'(f1);
                    "B": for (int r = 0; r < int'(f5); r++) begin
                        sendBurst(`WB_ID_W'(f1 + 64'(r)), `WB_USER_W'(f2), `WB_BURST'(f3),
                                  52'(f4 + 64'(r)));
                    end
                    "I": if (f3 == 0) begin
                        nextCycle();
                        issueValid = 1'b1;
                        issueId    = `WB_ID_W'(f1);
                        issueUser  = `WB_USER_W'(f2);
                    end else begin
                        heldId    = `WB_ID_W'(f1);        // Fires later from nextCycle
                        heldUser  = `WB_USER_W'(f2);
                        issueWait = int'(f3);
                    end
                    "C": if (f1 != 0) pairAck = 1'b1;
                         else begin
                             nextCycle();
                             writeModeAck = 1'b1;
                         end
                    "W": repeat (int'(f1)) nextCycle();
                    "O": begin
                        nextCycle();
                        chkValid = 1'b1;
                        chkCount = `WB_CNT_W'(f1);
                    end
                    default: ;                          // Comment or blank line
                endcase
            end
            $fclose(fd);
            repeat (4) nextCycle();
            $display("Checks run: %0d, errors: %0d", checkCount, errorCount);
            if (errorCount == 0) begin
                $display("Regression passed");
            end else begin
                $display("Regression failed");
            end
            $finish;
        end
    end

endmodule

// ==== testbench/wbChecker.sv ====
`timescale 1ns/1ns
`include "writeBuffer_defs.svh"

module wbChecker (
    input  logic                  clk, rst,
    input  logic [`WB_DATA_W-1:0] writeData, phyData,
    input  logic [`WB_ID_W-1:0]   writeDataId, writeAckId, issueId,
    input  logic [`WB_USER_W-1:0] writeDataUser, writeAckUser, issueUser,
    input  logic [`WB_BURST-1:0]  writeDataStrb,
    input  logic                  writeDataLast, writeDataValid, writeAckReady, writeAckValid,
    input  logic                  bufferFull, issueValid, phyFifoReady, writeModeAck,
    input  logic                  phyStrb, phyLast, phyValid,
    input  logic [`WB_CNT_W-1:0]  outstanding,
    input  logic                  chkValid,     // Trace checkpoint
    input  logic [`WB_CNT_W-1:0]  chkCount,
    output int                    errorCount, checkCount
);

    // --------------------
    // Reference model state
    // --------------------
    logic                  mValid  [`WB_DEPTH];
    logic                  mIssued [`WB_DEPTH];
    logic [`WB_ID_W-1:0]   mId     [`WB_DEPTH];
    logic [`WB_USER_W-1:0] mUser   [`WB_DEPTH];
    logic [`WB_BURST-1:0]  mStrb   [`WB_DEPTH];
    logic [`WB_DATA_W-1:0] mData   [`WB_DEPTH][`WB_BURST];
    logic                  inBusy, outBusy;             // Burst in progress on each side
    int                    inIdx, inBeat, outIdx, outBeat, count;
    logic                  expValid, expLast, expStrb;  // Due on the PHY at the next sample
    logic [`WB_DATA_W-1:0] expData;

    initial begin
        errorCount = 0;
        checkCount = 0;
    end

    task automatic compare(input string name, input logic [63:0] got, input logic [63:0] want);
        checkCount++;
        if (got !== want) begin
            errorCount++;
            $display("ERROR %s: got %h, expected %h at %0t ns", name, got, want, $time);
        end
    endtask

    // Index of the first flag set, or -1
    function automatic int lowestOf(input logic [`WB_DEPTH-1:0] flags);
        for (int i = 0; i < `WB_DEPTH; i++) begin
            if (flags[i]) return i;
        end
        return -1;
    endfunction

    // Inputs settle at the falling edge, so the rising edge sees one stable cycle
    always @(posedge clk) begin : model
        logic [`WB_DEPTH-1:0] freeMask, matchMask, issuedMask;
        logic                 accept;
        int                   pick, hit;
        if (!rst) begin
            for (int i = 0; i < `WB_DEPTH; i++) begin
                mValid[i]  = 1'b0;
                mIssued[i] = 1'b0;
            end
            inBusy   = 1'b0;
            outBusy  = 1'b0;
            inBeat   = 0;
            outBeat  = 0;
            count    = 0;
            expValid = 1'b0;
            expLast  = 1'b0;
        end else begin
            for (int i = 0; i < `WB_DEPTH; i++) begin
                freeMask[i]   = !mValid[i];
                issuedMask[i] = mIssued[i];
                matchMask[i]  = mValid[i] && !mIssued[i] && mId[i] == issueId
                                && mUser[i] == issueUser;
            end
            // --------------------
            // Frontend channel
            // --------------------
            accept = writeDataValid && (inBusy || |freeMask) && (!writeDataLast || writeAckReady);
            compare("bufferFull", bufferFull, ~|freeMask);
            compare("writeAckValid", writeAckValid, accept && writeDataLast);
            if (accept && writeDataLast) begin
                compare("writeAckId", writeAckId, writeDataId);
                compare("writeAckUser", writeAckUser, writeDataUser);
            end
            compare("outstanding", outstanding, count);
            if (chkValid) compare("outstanding", outstanding, chkCount);
            // Beat served in the previous cycle
            compare("phyValid", phyValid, expValid);
            compare("phyLast", phyLast, expLast);
            if (expValid) begin
                compare("phyData", phyData, expData);
                compare("phyStrb", phyStrb, expStrb);
            end
            if (accept) begin
                if (!inBusy) inIdx = lowestOf(freeMask);    // Entry fixed at the first beat
                mData[inIdx][inBeat] = writeData;
                inBusy = !writeDataLast;
                inBeat = writeDataLast ? 0 : inBeat + 1;
                if (writeDataLast) begin
                    mValid[inIdx]  = 1'b1;
                    mIssued[inIdx] = 1'b0;
                    mId[inIdx]     = writeDataId;
                    mUser[inIdx]   = writeDataUser;
                    mStrb[inIdx]   = writeDataStrb;
                end
            end
            count = count + int'(accept && writeDataLast) - int'(writeModeAck);
            hit = lowestOf(matchMask);                      // Lowest waiting match
            if (issueValid && hit >= 0) mIssued[hit] = 1'b1;
            // --------------------
            // PHY channel
            // --------------------
            pick     = outBusy ? outIdx : lowestOf(issuedMask);
            expValid = phyFifoReady && pick >= 0;
            expLast  = 1'b0;
            if (expValid) begin
                expData = mData[pick][outBeat];
                expStrb = mStrb[pick][outBeat];
                expLast = (outBeat == `WB_BURST - 1);
                outIdx  = pick;
                outBusy = !expLast;
                outBeat = expLast ? 0 : outBeat + 1;
                if (expLast) begin
                    mValid[pick]  = 1'b0;                   // Free after the last beat
                    mIssued[pick] = 1'b0;
                end
            end
        end
    end

endmodule

// ==== testbench/writeBuffer_trace.txt ====
# Each line is a kind letter and hex fields. B id user strb base count. I id user delay
# R phyReady with 2 for random. A ackReady low cycles. C pair with next last. W cycles. O count
R 1
A c
B 1 0 ff 10 1
B 2 1 a5 20 1
O 2
I 2 1 0
W 3
I 1 0 0
W 18
C 0
O 1
C 1
B 3 0 3c 30 1
O 1
R 2
B 4 1 f0 40 2
I 4 1 0
I 3 0 0
I 5 1 0
W 40
R 1
C 0
C 0
C 0
O 0
B 0 0 81 a0 8
O 8
I 2 0 5
B 8 1 c3 b0 1
W 1e
O 9

// ==== writeBufferCtrl.f ====
+incdir+rtl
rtl/writeBufferPkg.sv
rtl/burstIntake.sv
rtl/entryDirectory.sv
rtl/burstStreamer.sv
rtl/burstDataRam.sv
rtl/writeBufferCtrl.sv
testbench/wbChecker.sv
testbench/tbWriteBuffer.sv
